// File: source/ex_settings.svh
// Widths are fixed for the 16-bit ISA; the ALU and PC logic assume a 16-bit word and 8-bit bytes
`ifndef EX_SETTINGS_SVH
`define EX_SETTINGS_SVH

////////////////////
// Datapath sizes
////////////////////

`define EX_WORD_WIDTH        16 // Data and PC width
`define EX_REG_ADDR_WIDTH    4  // Register number width

////////////////////
// Control constants
////////////////////

`define EX_SP_REG            15 // Stack pointer register number
`define EX_CALL_TARGET_WIDTH 12 // Absolute call field width

`endif

// File: source/isa_pkg.sv
// ISA types for the execute stage; encodings follow the 3-bit opcode fields of the decoder
`include "ex_settings.svh"

package isa_pkg;

    ////////////////////
    // Basic words
    ////////////////////

    typedef logic [`EX_WORD_WIDTH-1:0]     word_t;     // Data or PC word
    typedef logic [`EX_REG_ADDR_WIDTH-1:0] reg_addr_t; // Register number

    ////////////////////
    // ALU operations
    ////////////////////

    typedef enum logic [2:0] {
        alu_add = 3'b000, // Wrapping add
        alu_sub = 3'b001, // Wrapping subtract
        alu_and = 3'b010, // Bitwise and
        alu_nor = 3'b011, // Bitwise nor
        alu_sll = 3'b100, // Logical left shift
        alu_srl = 3'b101, // Logical right shift
        alu_sra = 3'b110, // Arithmetic right shift
        alu_lhb = 3'b111  // Load high byte
    } alu_op_e;

    ////////////////////
    // Branch conditions
    ////////////////////

    typedef enum logic [2:0] {
        cond_ne     = 3'b000, // Not equal
        cond_eq     = 3'b001, // Equal
        cond_gt     = 3'b010, // Greater than
        cond_lt     = 3'b011, // Less than
        cond_gte    = 3'b100, // Greater or equal
        cond_lte    = 3'b101, // Less or equal
        cond_ovfl   = 3'b110, // Overflow
        cond_always = 3'b111  // Unconditional
    } branch_cond_e;

    typedef struct packed {
        logic z; // Zero
        logic v; // Signed overflow
        logic n; // Negative
    } flags_t;

endpackage

// File: source/pipe_pkg.sv
// Stage bundles between decode, execute and memory; operands arrive already forwarded
`include "ex_settings.svh"

package pipe_pkg;

    import isa_pkg::*;

    ////////////////////
    // Execute input
    ////////////////////

    typedef struct packed {
        logic         reg_write;   // Write back to regfile
        logic         mem_to_reg;  // Load
        logic         reg_to_mem;  // Store
        logic         ret_future;  // Return pending in writeback
        logic         alu_src;     // Second operand from sign_ext
        logic         branch;      // Conditional branch
        logic         call;        // Call
        logic         ret;         // Return
        alu_op_e      alu_op;
        logic [3:0]   shift;       // Shift amount
        logic [7:0]   load_half_imm;
        branch_cond_e branch_cond;
        logic [`EX_CALL_TARGET_WIDTH-1:0] call_target; // Absolute call field
        word_t        pc;          // Already incremented
        word_t        rd_data_1;
        word_t        rd_data_2;
        word_t        sign_ext;    // Sign extended immediate
        word_t        ret_addr;    // Return address from the stack
        reg_addr_t    reg_rd;      // Destination register
    } ex_in_t;

    ////////////////////
    // Memory stage
    ////////////////////

    typedef struct packed {
        logic      reg_write;
        logic      mem_to_reg;
        logic      reg_to_mem;
        logic      ret_future;
        logic      call;       // Tells memory stage to move SP
        reg_addr_t reg_rd;     // SP for call and ret_future
        word_t     alu_result;
        word_t     sw_data;    // Return PC on a call
    } ex_mem_t;

    typedef struct packed {
        word_t target; // New fetch PC
    } pc_redirect_t;

endpackage

// File: source/alu.sv
// Purely combinational; lhb and the overflow logic assume a 16-bit word
`timescale 1ns/1ps

module alu (
    input  isa_pkg::word_t   op_a,          // From rd_data_1
    input  isa_pkg::word_t   op_b,          // Register or immediate
    input  logic [3:0]       shift,         // Shift amount
    input  logic [7:0]       load_half_imm, // High byte for lhb
    input  isa_pkg::alu_op_e op,
    output isa_pkg::word_t   result,
    output isa_pkg::flags_t  flags
);

    import isa_pkg::*;

    word_t sum;  // op_a + op_b
    word_t diff; // op_a - op_b
    logic  add_ovfl;
    logic  sub_ovfl;

    ////////////////////
    // Arithmetic
    ////////////////////

    assign sum  = op_a + op_b;  // Wraps
    assign diff = op_a - op_b;  // Wraps

    // Same-sign operands giving a result of the other sign
    assign add_ovfl = (op_a[15] == op_b[15]) && (sum[15] != op_a[15]);
    // Opposite-sign operands, result sign differs from op_a
    assign sub_ovfl = (op_a[15] != op_b[15]) && (diff[15] != op_a[15]);

    ////////////////////
    // Result select
    ////////////////////

    always_comb begin
        unique case (op)
            alu_add: result = sum;
            alu_sub: result = diff;
            alu_and: result = op_a & op_b;
            alu_nor: result = ~(op_a | op_b);
            alu_sll: result = op_a << shift;
            alu_srl: result = op_a >> shift;
            alu_sra: result = word_t'($signed(op_a) >>> shift); // Sign fill
            alu_lhb: result = {load_half_imm, op_a[7:0]};       // Keep low byte
            default: result = '0;
        endcase
    end

    ////////////////////
    // Flags
    ////////////////////

    always_comb begin
        flags.z = (result == '0); // Zero result
        flags.n = result[15];     // Sign bit
        unique case (op)
            alu_add: flags.v = add_ovfl;
            alu_sub: flags.v = sub_ovfl;
            default: flags.v = 1'b0; // Only add and sub overflow
        endcase
    end

endmodule

// File: source/flag_unit.sv
// Flags update one cycle after the write; the condition is tested against the stored value
`timescale 1ns/1ps

module flag_unit (
    input  logic                  clk,
    input  logic                  reset,     // Sync, clears flags
    input  logic                  write,     // Load new_flags
    input  isa_pkg::flags_t       new_flags, // From the ALU
    input  isa_pkg::branch_cond_e cond,
    output logic                  cond_met   // Condition holds on stored flags
);

    import isa_pkg::*;

    flags_t flags_q; // Stored flags

    ////////////////////
    // Flag register
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            flags_q <= '0;
        end else if (write) begin
            flags_q <= new_flags;
        end
    end

    ////////////////////
    // Condition check
    ////////////////////

    always_comb begin
        unique case (cond)
            cond_ne:     cond_met = ~flags_q.z;
            cond_eq:     cond_met = flags_q.z;
            cond_gt:     cond_met = ~flags_q.z & ~flags_q.n; // Strictly positive
            cond_lt:     cond_met = flags_q.n;
            cond_gte:    cond_met = flags_q.z | ~flags_q.n;
            cond_lte:    cond_met = flags_q.n | flags_q.z;
            cond_ovfl:   cond_met = flags_q.v;
            cond_always: cond_met = 1'b1;
            default:     cond_met = 1'b0;
        endcase
    end

endmodule

// File: source/pc_update.sv
// Combinational; call, ret and branch are expected one-hot, call wins if several are set
`timescale 1ns/1ps
`include "ex_settings.svh"

module pc_update (
    input  isa_pkg::word_t                   pc,          // Already incremented
    input  isa_pkg::word_t                   sign_ext,    // Branch offset
    input  logic [`EX_CALL_TARGET_WIDTH-1:0] call_target, // Absolute call field
    input  isa_pkg::word_t                   ret_addr,    // From the stack
    input  logic                             branch,
    input  logic                             call,
    input  logic                             ret,
    input  logic                             cond_met,    // From flag_unit
    output logic                             taken,
    output isa_pkg::word_t                   target
);

    import isa_pkg::*;

    word_t call_pc;   // Page of pc joined with call field
    word_t branch_pc; // Relative branch target

    ////////////////////
    // Candidate targets
    ////////////////////

    assign call_pc   = {pc[`EX_WORD_WIDTH-1:`EX_CALL_TARGET_WIDTH], call_target};
    assign branch_pc = pc + sign_ext; // Wraps

    ////////////////////
    // Outcome
    ////////////////////

    always_comb begin
        taken  = 1'b0;
        target = pc; // Fall through when not taken
        if (call) begin
            taken  = 1'b1;
            target = call_pc;
        end else if (ret) begin
            taken  = 1'b1;
            target = ret_addr;
        end else if (branch && cond_met) begin
            taken  = 1'b1;
            target = branch_pc;
        end
    end

endmodule

// File: source/pipe_reg.sv
// Single entry; ready passes downstream ready through combinationally, so chains add ready depth
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic // Carried bundle
) (
    input  logic     clk,
    input  logic     reset,     // Sync, clears valid only
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,  // Empty or draining
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    ////////////////////
    // Handshake
    ////////////////////

    assign in_ready = ~out_valid | out_ready; // Room this cycle

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            out_valid <= 1'b1; // New item replaces drained one
        end else if (out_ready) begin
            out_valid <= 1'b0; // Drained, nothing new
        end
    end

    // Payload held until the next accepted item
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

endmodule

// File: source/ex_unit.sv
// No forwarding here; operands and ret_addr arrive resolved, and both outputs must be ready to accept
`timescale 1ns/1ps
`include "ex_settings.svh"

module ex_unit (
    input  logic                  clk,
    input  logic                  reset,          // Sync, active high
    input  pipe_pkg::ex_in_t      in,             // Decoded instruction
    input  logic                  in_valid,
    output logic                  in_ready,       // Both outputs have room
    output pipe_pkg::ex_mem_t     mem_out,        // To memory stage
    output logic                  mem_valid,
    input  logic                  mem_ready,
    output pipe_pkg::pc_redirect_t redirect,      // To fetch
    output logic                  redirect_valid,
    input  logic                  redirect_ready
);

    import isa_pkg::*;
    import pipe_pkg::*;

    word_t        op_b;              // Second ALU operand
    word_t        alu_result;
    flags_t       alu_flags;         // Flags from this instruction
    logic         cond_met;          // Condition on stored flags
    logic         taken;             // Redirect needed
    word_t        target;
    logic         mem_in_ready;
    logic         redirect_in_ready;
    logic         accept;            // Input transfer this cycle
    ex_mem_t      mem_next;
    pc_redirect_t redirect_next;

    ////////////////////
    // Handshake join
    ////////////////////

    assign in_ready = mem_in_ready & redirect_in_ready;
    assign accept   = in_valid & in_ready;

    ////////////////////
    // Operand and bundle
    ////////////////////

    assign op_b = in.alu_src ? in.sign_ext : in.rd_data_2; // Immediate or register

    always_comb begin
        mem_next.reg_write  = in.reg_write;
        mem_next.mem_to_reg = in.mem_to_reg;
        mem_next.reg_to_mem = in.reg_to_mem;
        mem_next.ret_future = in.ret_future;
        mem_next.call       = in.call;
        mem_next.alu_result = alu_result;
        mem_next.sw_data    = in.call ? in.pc : in.rd_data_2; // Return PC pushed on a call
        if (in.call || in.ret_future) begin
            mem_next.reg_rd = reg_addr_t'(`EX_SP_REG); // SP is the destination
        end else begin
            mem_next.reg_rd = in.reg_rd;
        end
    end

    assign redirect_next.target = target;

    ////////////////////
    // Datapath
    ////////////////////

    alu u_alu (
        .op_a          (in.rd_data_1),
        .op_b          (op_b),
        .shift         (in.shift),
        .load_half_imm (in.load_half_imm),
        .op            (in.alu_op),
        .result        (alu_result),
        .flags         (alu_flags)
    );

    flag_unit u_flag_unit (
        .clk       (clk),
        .reset     (reset),
        .write     (accept && (in.alu_op != alu_lhb)), // lhb keeps flags
        .new_flags (alu_flags),
        .cond      (in.branch_cond),
        .cond_met  (cond_met)
    );

    pc_update u_pc_update (
        .pc          (in.pc),
        .sign_ext    (in.sign_ext),
        .call_target (in.call_target),
        .ret_addr    (in.ret_addr),
        .branch      (in.branch),
        .call        (in.call),
        .ret         (in.ret),
        .cond_met    (cond_met),
        .taken       (taken),
        .target      (target)
    );

    ////////////////////
    // Output registers
    ////////////////////

    pipe_reg #(.payload_t(ex_mem_t)) u_mem_reg (
        .clk       (clk),
        .reset     (reset),
        .in_data   (mem_next),
        .in_valid  (accept),         // Every instruction
        .in_ready  (mem_in_ready),
        .out_data  (mem_out),
        .out_valid (mem_valid),
        .out_ready (mem_ready)
    );

    pipe_reg #(.payload_t(pc_redirect_t)) u_redirect_reg (
        .clk       (clk),
        .reset     (reset),
        .in_data   (redirect_next),
        .in_valid  (accept & taken), // Taken control only
        .in_ready  (redirect_in_ready),
        .out_data  (redirect),
        .out_valid (redirect_valid),
        .out_ready (redirect_ready)
    );

endmodule

// File: verification/ex_unit_tb_ref.svh
// Expected results from the ISA rules; needs isa_pkg and pipe_pkg imported and a 16-bit word
`ifndef EX_UNIT_TB_REF_SVH
`define EX_UNIT_TB_REF_SVH

function automatic word_t alu_value(input ex_in_t x);
    word_t a;
    word_t b;
    word_t r;
    a = x.rd_data_1;
    b = x.alu_src ? x.sign_ext : x.rd_data_2; // Immediate or register
    case (x.alu_op)
        alu_add: r = a + b;
        alu_sub: r = a + ~b + 16'd1;          // Two's complement negate
        alu_and: r = a & b;
        alu_nor: r = ~a & ~b;                 // De Morgan form
        alu_sll: r = a << x.shift;
        alu_srl: r = a >> x.shift;
        alu_sra: r = (a >> x.shift) | (a[15] ? ~(16'hffff >> x.shift) : 16'h0000);
        default: r = {x.load_half_imm, a[7:0]}; // lhb
    endcase
    return r;
endfunction

function automatic flags_t flags_after(input ex_in_t x);
    flags_t f;
    word_t  r;
    int     sa;   // Operands as signed integers
    int     sb;
    int     wide; // Exact result before wrap
    r   = alu_value(x);
    sa  = $signed(x.rd_data_1);
    sb  = $signed(x.alu_src ? x.sign_ext : x.rd_data_2);
    f.z = (r == 16'h0000);
    f.n = r[15];
    f.v = 1'b0;
    if (x.alu_op == alu_add || x.alu_op == alu_sub) begin
        wide = (x.alu_op == alu_add) ? sa + sb : sa - sb;
        f.v  = (wide > 32767) || (wide < -32768); // Out of 16-bit signed range
    end
    return f;
endfunction

function automatic logic cond_holds(input flags_t f, input branch_cond_e c);
    case (c)
        cond_ne:  return !f.z;
        cond_eq:  return f.z;
        cond_gt:  return !f.z && !f.n;
        cond_lt:  return f.n;
        cond_gte: return f.z || !f.n;
        cond_lte: return f.z || f.n;
        cond_ovfl: return f.v;
        default:  return 1'b1;                    // always
    endcase
endfunction

function automatic logic redirect_taken(input ex_in_t x, input flags_t f);
    return x.call || x.ret || (x.branch && cond_holds(f, x.branch_cond));
endfunction

function automatic pc_redirect_t target_of(input ex_in_t x);
    pc_redirect_t t;
    if (x.call)
        t.target = {x.pc[15:12], x.call_target}; // Same 4K page
    else if (x.ret)
        t.target = x.ret_addr;
    else
        t.target = x.pc + x.sign_ext;
    return t;
endfunction

function automatic ex_mem_t mem_bundle_of(input ex_in_t x);
    ex_mem_t m;
    m.reg_write  = x.reg_write;
    m.mem_to_reg = x.mem_to_reg;
    m.reg_to_mem = x.reg_to_mem;
    m.ret_future = x.ret_future;
    m.call       = x.call;
    m.reg_rd     = (x.call || x.ret_future) ? 4'd`EX_SP_REG : x.reg_rd;
    m.alu_result = alu_value(x);
    m.sw_data    = x.call ? x.pc : x.rd_data_2; // Return PC on a call
    return m;
endfunction

`endif

// File: verification/ex_unit_tb.sv
// At most one of branch, call and ret per instruction; output ready is random only in back-pressure
`timescale 1ns/1ps
`include "ex_settings.svh"

module ex_unit_tb;

    import isa_pkg::*;
    import pipe_pkg::*;

    `include "ex_unit_tb_ref.svh"

    logic         clk = 1'b0;
    logic         reset;
    ex_in_t       in;
    logic         in_valid;
    logic         in_ready;
    ex_mem_t      mem_out;
    logic         mem_valid;
    logic         mem_ready;
    pc_redirect_t redirect;
    logic         redirect_valid;
    logic         redirect_ready;
    ex_mem_t      mem_q[$];   // Expected memory bundles
    pc_redirect_t redir_q[$]; // Expected redirects
    flags_t       flags_m;    // Mirror of stored flags
    logic         bp_mode;    // Random output ready
    int           errors = 0;
    int           checks = 0;
    int           issued = 0;
    int           cycles = 0;
    word_t        setup_a[4]  = '{16'h0001, 16'h7fff, 16'h0001, 16'h0000}; // Op b is always 1
    alu_op_e      setup_op[4] = '{alu_sub, alu_add, alu_add, alu_sub};     // z, v+n, clear, n

    ex_unit DUT (
        .clk (clk), .reset (reset),
        .in (in), .in_valid (in_valid), .in_ready (in_ready),
        .mem_out (mem_out), .mem_valid (mem_valid), .mem_ready (mem_ready),
        .redirect (redirect), .redirect_valid (redirect_valid), .redirect_ready (redirect_ready)
    );

    always #50 clk = ~clk; // 100 ns period

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > 8 * issued + 200) begin // Budget grows with each instruction
            $display("Timeout after %0d cycles with %0d instructions issued", cycles, issued);
            $display("Verification failed");
            $finish;
        end
    end

    ////////////////////
    // Scoreboard
    ////////////////////

    task automatic check_mem(input ex_mem_t got, input ex_mem_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: mem_out %h (alu_result %h), expected %h (alu_result %h)",
                     $time, got, got.alu_result, exp, exp.alu_result);
        end
    endtask

    task automatic check_redirect(input pc_redirect_t got, input pc_redirect_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: redirect target %h, expected %h", $time, got, exp);
        end
    endtask

    // Outputs popped before inputs pushed, so a new item never matches itself
    always @(posedge clk) begin
        if (!reset) begin
            if (mem_valid && mem_ready) begin
                if (mem_q.size() == 0) begin
                    errors++;
                    $display("Memory bundle arrived at %0t ns with nothing expected", $time);
                end else begin
                    check_mem(mem_out, mem_q.pop_front());
                end
            end
            if (redirect_valid && redirect_ready) begin
                if (redir_q.size() == 0) begin
                    errors++;
                    $display("Redirect arrived at %0t ns with nothing expected", $time);
                end else begin
                    check_redirect(redirect, redir_q.pop_front());
                end
            end
            if (in_valid && in_ready) begin
                mem_q.push_back(mem_bundle_of(in));
                if (redirect_taken(in, flags_m))
                    redir_q.push_back(target_of(in));
                if (in.alu_op != alu_lhb)
                    flags_m = flags_after(in); // Visible to the next instruction
            end
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    task automatic shake_ready();
        mem_ready      = bp_mode ? 1'($urandom) : 1'b1;
        redirect_ready = bp_mode ? 1'($urandom) : 1'b1;
    endtask

    task automatic issue(input ex_in_t x);
        issued++;
        @(negedge clk);
        in       = x;
        in_valid = 1'b1;
        shake_ready();
        @(posedge clk);
        while (!in_ready) begin // Hold until accepted
            @(negedge clk);
            shake_ready();
            @(posedge clk);
        end
    endtask

    task automatic drain();
        @(negedge clk);
        in_valid = 1'b0;
        shake_ready();
        while (mem_q.size() != 0 || redir_q.size() != 0) begin
            @(negedge clk);
            shake_ready();
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        drain();
        $display("Test %-12s %s", name, (errors == err_before) ? "ok" : "had errors");
    endtask

    function automatic ex_in_t rand_instr(input logic ctrl);
        logic [127:0] bits;
        ex_in_t       x;
        bits     = {$urandom, $urandom, $urandom, $urandom};
        x        = bits[$bits(ex_in_t)-1:0];
        x.branch = 1'b0;
        x.call   = 1'b0;
        x.ret    = 1'b0;
        if (ctrl) begin
            case ($urandom % 4)
                1: x.branch = 1'b1;
                2: x.call = 1'b1;
                3: x.ret = 1'b1;
                default: x.branch = 1'b0; // Plain ALU instruction
            endcase
        end
        return x;
    endfunction

    function automatic ex_in_t alu_instr(input alu_op_e op, input word_t a, input word_t b);
        ex_in_t x;
        x           = '0;
        x.alu_op    = op;
        x.rd_data_1 = a;
        x.rd_data_2 = b;
        x.reg_write = 1'b1;
        x.reg_rd    = 4'd3;
        return x;
    endfunction

    initial begin
        int     e;
        ex_in_t x;
        void'($urandom(34));
        reset = 1'b1;
        in = '0;
        in_valid = 1'b0;
        bp_mode = 1'b0;
        flags_m = '0;
        shake_ready();
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        e = errors; // Reset
        @(negedge clk);
        if (mem_valid !== 1'b0 || redirect_valid !== 1'b0) begin
            errors++;
            $display("** Error at %0t ns: output valid high after reset", $time);
        end
        end_test("reset", e);

        e = errors; // ALU corners then random
        issue(alu_instr(alu_add, 16'h7fff, 16'h0001));
        issue(alu_instr(alu_sub, 16'h8000, 16'h0001));
        issue(alu_instr(alu_nor, 16'h0000, 16'h0000));
        x = alu_instr(alu_sra, 16'h8001, 16'h0000);
        x.shift = 4'd15;
        issue(x);
        x = alu_instr(alu_lhb, 16'h12ab, 16'h0000);
        x.load_half_imm = 8'hcd;
        issue(x);
        repeat (500) issue(rand_instr(1'b0));
        end_test("alu", e);

        e = errors; // Each condition after each flag setup
        foreach (setup_a[i]) begin
            for (int c = 0; c < 8; c++) begin
                issue(alu_instr(setup_op[i], setup_a[i], 16'h0001));
                x = '0;
                x.branch = 1'b1;
                x.branch_cond = branch_cond_e'(c);
                x.pc = 16'h0100 + 16'(c);
                x.sign_ext = 16'hfff0;
                issue(x);
            end
        end
        issue(alu_instr(alu_sub, 16'h0003, 16'h0003)); // z set
        x = alu_instr(alu_lhb, 16'h00ff, 16'h0000);
        x.load_half_imm = 8'h80; // Nonzero negative result leaves flags alone
        issue(x);
        x = '0;
        x.branch = 1'b1;
        x.branch_cond = cond_eq;
        x.sign_ext = 16'h0040;
        issue(x);
        end_test("flags", e);

        e = errors; // Call, return, ret_future
        x = '0;
        x.call = 1'b1;
        x.pc = 16'ha123;
        x.call_target = 12'h456;
        x.reg_rd = 4'd2;
        issue(x);
        x = '0;
        x.ret = 1'b1;
        x.ret_future = 1'b1;
        x.ret_addr = 16'h0abc;
        issue(x);
        x = alu_instr(alu_add, 16'h0010, 16'h0002);
        x.ret_future = 1'b1;
        issue(x);
        end_test("call_ret", e);

        e = errors;
        repeat (100) issue(rand_instr(1'b0));
        end_test("passthrough", e);

        e = errors;
        bp_mode = 1'b1;
        repeat (1000) issue(rand_instr(1'b1));
        end_test("backpressure", e);
        bp_mode = 1'b0;
        shake_ready(); // Stray items still get drained and flagged

        repeat (5) @(posedge clk);
        if (mem_q.size() != 0 || redir_q.size() != 0) begin
            errors++;
            $display("%0d memory and %0d redirect items never arrived",
                     mem_q.size(), redir_q.size());
        end
        $display("Instructions %0d, checks %0d, errors %0d", issued, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+source
+incdir+verification
source/isa_pkg.sv
source/pipe_pkg.sv
source/alu.sv
source/flag_unit.sv
source/pc_update.sv
source/pipe_reg.sv
source/ex_unit.sv
verification/ex_unit_tb.sv

// File: Bender.yml
package:
  name: ex_unit

sources:
  - include_dirs:
      - source
    files:
      - source/isa_pkg.sv
      - source/pipe_pkg.sv
      - source/alu.sv
      - source/flag_unit.sv
      - source/pc_update.sv
      - source/pipe_reg.sv
      - source/ex_unit.sv
  - target: simulation
    include_dirs:
      - source
      - verification
    files:
      - verification/ex_unit_tb.sv
